/* design/lsuPkg.sv */
// ---------------------------
// Shared types and constants for the load/store data path.
// ---------------------------

package lsuPkg;

    localparam int XLEN       = 32;                 // address and data width.
    localparam int BYTE_W     = 8;
    localparam int HALF_W     = 16;
    localparam int BYTE_LANES = XLEN / BYTE_W;      // four lanes per memory word.
    localparam int LANE_BITS  = $clog2(BYTE_LANES); // byte offset inside a word.

    // Memory opcodes follow the funct3 field of the RV32I loads and stores.
    typedef enum logic [2:0] {
        memByte  = 3'b000,                          // sign-extended on load.
        memHalf  = 3'b001,                          // sign-extended on load.
        memWord  = 3'b010,
        memByteU = 3'b100,                          // loads only.
        memHalfU = 3'b101                           // loads only.
    } memOpE;

    // Lane masks for each access size, before the shift by the byte offset.
    localparam logic [BYTE_LANES-1:0] MASK_BYTE = BYTE_LANES'(1);
    localparam logic [BYTE_LANES-1:0] MASK_HALF = BYTE_LANES'(3);
    localparam logic [BYTE_LANES-1:0] MASK_WORD = '1;

endpackage

/* design/lsuStageIf.sv */
// ---------------------------
// Stage-to-stage interfaces: request into memory, response out of it.
// ---------------------------
`timescale 1ns/1ps

interface memReqIf #(
    parameter int DEPTH_WORDS = 256
);
    logic                              valid;
    logic                              isLoad;
    lsuPkg::memOpE                     memOp;
    logic [$clog2(DEPTH_WORDS)-1:0]    wordAddr;
    logic [lsuPkg::LANE_BITS-1:0]      byteOff;
    logic [lsuPkg::BYTE_LANES-1:0]     laneEn;   // all low for loads and faults.
    logic [lsuPkg::XLEN-1:0]           wrData;   // already placed in its lanes.
    logic                              fault;

    modport src (output valid, isLoad, memOp, wordAddr, byteOff, laneEn, wrData, fault);
    modport dst (input  valid, isLoad, memOp, wordAddr, byteOff, laneEn, wrData, fault);
endinterface

interface memRspIf;
    logic                              valid;
    logic                              isLoad;
    lsuPkg::memOpE                     memOp;
    logic [lsuPkg::LANE_BITS-1:0]      byteOff;
    logic [lsuPkg::XLEN-1:0]           rawWord;  // whole word, not yet aligned.
    logic                              fault;

    modport src (output valid, isLoad, memOp, byteOff, rawWord, fault);
    modport dst (input  valid, isLoad, memOp, byteOff, rawWord, fault);
endinterface

/* design/lsuAddrGen.sv */
// ---------------------------
// Stage 1: effective address, opcode and alignment checks, request register.
// ---------------------------
`timescale 1ns/1ps

module lsuAddrGen #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    reqValid,
    input  logic                    wrEn,
    input  lsuPkg::memOpE           memOp,
    input  logic [lsuPkg::XLEN-1:0] base,
    input  logic [lsuPkg::XLEN-1:0] offset,
    input  logic [lsuPkg::XLEN-1:0] wrData,
    memReqIf.src                    req
);

    localparam int WORD_AW = $clog2(DEPTH_WORDS);
    localparam int IDX_W   = lsuPkg::XLEN - lsuPkg::LANE_BITS;
    localparam logic [IDX_W-1:0] WORD_LIMIT = IDX_W'(DEPTH_WORDS);

    logic                           inValid;
    logic                           inWrEn;
    lsuPkg::memOpE                  inOp;
    logic [lsuPkg::XLEN-1:0]        inBase;
    logic [lsuPkg::XLEN-1:0]        inOffset;
    logic [lsuPkg::XLEN-1:0]        inData;

    logic [lsuPkg::XLEN-1:0]        effAddr;
    logic [lsuPkg::LANE_BITS-1:0]   byteOff;
    logic [IDX_W-1:0]               wordIdx;
    logic                           opLegal;
    logic                           aligned;
    logic                           inRange;
    logic                           isFault;
    logic [lsuPkg::BYTE_LANES-1:0]  sizeMask;
    logic [lsuPkg::XLEN-1:0]        laneData;

    // ---------------------------
    // input capture
    // ---------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            inValid <= 1'b0;
        end else begin
            inValid <= reqValid;
        end
    end

    always_ff @(posedge clk) begin
        inWrEn   <= wrEn;
        inOp     <= memOp;
        inBase   <= base;
        inOffset <= offset;
        inData   <= wrData;
    end

    // ---------------------------
    // address and checks
    // ---------------------------
    assign effAddr = inBase + inOffset;
    assign byteOff = effAddr[lsuPkg::LANE_BITS-1:0];
    assign wordIdx = effAddr[lsuPkg::XLEN-1:lsuPkg::LANE_BITS];
    assign inRange = wordIdx < WORD_LIMIT;  // the adder may carry past the array.

    // Narrow store data is copied into every lane and the lane enables pick one.
    always_comb begin
        opLegal  = 1'b1;
        aligned  = 1'b1;
        sizeMask = '0;
        laneData = '0;
        case (inOp)
            lsuPkg::memByte: begin
                sizeMask = lsuPkg::MASK_BYTE;
                laneData = {lsuPkg::BYTE_LANES{inData[lsuPkg::BYTE_W-1:0]}};
            end
            lsuPkg::memHalf: begin
                aligned  = ~byteOff[0];
                sizeMask = lsuPkg::MASK_HALF;
                laneData = {(lsuPkg::XLEN / lsuPkg::HALF_W){inData[lsuPkg::HALF_W-1:0]}};
            end
            lsuPkg::memWord: begin
                aligned  = (byteOff == '0);
                sizeMask = lsuPkg::MASK_WORD;
                laneData = inData;
            end
            lsuPkg::memByteU: opLegal = ~inWrEn;   // no unsigned store exists.
            lsuPkg::memHalfU: begin
                opLegal = ~inWrEn;
                aligned = ~byteOff[0];
            end
            default: opLegal = 1'b0;              // 011, 110 and 111 are undefined.
        endcase
    end

    assign isFault = ~opLegal | ~aligned | ~inRange;

    // ---------------------------
    // request register
    // ---------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            req.valid <= 1'b0;
            req.fault <= 1'b0;
        end else begin
            req.valid <= inValid;
            req.fault <= inValid & isFault;
        end
    end

    always_ff @(posedge clk) begin
        req.isLoad   <= ~inWrEn;
        req.memOp    <= inOp;
        req.wordAddr <= effAddr[lsuPkg::LANE_BITS +: WORD_AW];
        req.byteOff  <= byteOff;
        req.laneEn   <= (inValid & inWrEn & ~isFault) ? (sizeMask << byteOff) : '0;
        req.wrData   <= laneData;
    end

endmodule

/* design/lsuDataMem.sv */
// ---------------------------
// Stage 2: word memory with byte-lane writes and a registered read port.
// ---------------------------
`timescale 1ns/1ps

module lsuDataMem #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic clk,
    input  logic rstN,
    memReqIf.dst req,
    memRspIf.src rsp
);

    localparam int BYTE_W = lsuPkg::BYTE_W;

    logic [lsuPkg::XLEN-1:0] mem [DEPTH_WORDS];  // contents survive reset.
    logic                    rdEn;

    // A faulting load skips the read since its data is discarded downstream.
    assign rdEn = req.valid & req.isLoad & ~req.fault;

    // ---------------------------
    // write port
    // ---------------------------
    // Only one request sits in this stage per cycle, so a write and a read
    // never meet at the same edge.
    always_ff @(posedge clk) begin
        if (req.valid) begin
            for (int lane = 0; lane < lsuPkg::BYTE_LANES; lane++) begin
                if (req.laneEn[lane]) begin
                    mem[req.wordAddr][lane*BYTE_W +: BYTE_W] <=
                        req.wrData[lane*BYTE_W +: BYTE_W];  // untouched lanes keep data.
                end
            end
        end
    end

    // ---------------------------
    // read port
    // ---------------------------
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rsp.rawWord <= mem[req.wordAddr];  // whole word, lane pick comes later.
        end
    end

    // ---------------------------
    // response register
    // ---------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rsp.valid <= 1'b0;
            rsp.fault <= 1'b0;
        end else begin
            rsp.valid <= req.valid;
            rsp.fault <= req.valid & req.fault;
        end
    end

    // These fields travel alongside the read so stage 3 can align the word.
    always_ff @(posedge clk) begin
        rsp.isLoad  <= req.isLoad;
        rsp.memOp   <= req.memOp;
        rsp.byteOff <= req.byteOff;
    end

endmodule

/* design/lsuLoadAlign.sv */
// ---------------------------
// Stage 3: lane select, sign or zero extension, output register.
// ---------------------------
`timescale 1ns/1ps

module lsuLoadAlign (
    input  logic                    clk,
    input  logic                    rstN,
    memRspIf.dst                    rsp,
    output logic                    rdValid,
    output logic [lsuPkg::XLEN-1:0] rdData,
    output logic                    fault
);

    localparam int XLEN   = lsuPkg::XLEN;
    localparam int BYTE_W = lsuPkg::BYTE_W;
    localparam int HALF_W = lsuPkg::HALF_W;

    logic [BYTE_W-1:0] byteSel;
    logic [HALF_W-1:0] halfSel;
    logic [XLEN-1:0]   loadWord;

    assign byteSel = rsp.rawWord[rsp.byteOff*BYTE_W +: BYTE_W];
    assign halfSel = rsp.rawWord[rsp.byteOff[lsuPkg::LANE_BITS-1]*HALF_W +: HALF_W];

    always_comb begin
        case (rsp.memOp)
            lsuPkg::memByte:  loadWord = {{(XLEN-BYTE_W){byteSel[BYTE_W-1]}}, byteSel};
            lsuPkg::memHalf:  loadWord = {{(XLEN-HALF_W){halfSel[HALF_W-1]}}, halfSel};
            lsuPkg::memWord:  loadWord = rsp.rawWord;
            lsuPkg::memByteU: loadWord = {{(XLEN-BYTE_W){1'b0}}, byteSel};
            lsuPkg::memHalfU: loadWord = {{(XLEN-HALF_W){1'b0}}, halfSel};
            default:          loadWord = '0;
        endcase
        if (rsp.fault) begin
            loadWord = '0;  // rawWord is stale when the read was skipped.
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdValid <= 1'b0;
            fault   <= 1'b0;
            rdData  <= '0;
        end else begin
            rdValid <= rsp.valid & rsp.isLoad;  // stores complete silently.
            fault   <= rsp.valid & rsp.fault;
            if (rsp.valid & rsp.isLoad) begin
                rdData <= loadWord;  // held between loads.
            end
        end
    end

endmodule

/* design/lsuTop.sv */
// ---------------------------
// Load/store data path top level: three pipeline stages.
// ---------------------------
`timescale 1ns/1ps

module lsuTop #(
    parameter int DEPTH_WORDS = 256  // memory size in words, a power of two.
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    reqValid,
    input  logic                    wrEn,
    input  lsuPkg::memOpE           memOp,
    input  logic [lsuPkg::XLEN-1:0] base,
    input  logic [lsuPkg::XLEN-1:0] offset,
    input  logic [lsuPkg::XLEN-1:0] wrData,
    output logic                    rdValid,
    output logic [lsuPkg::XLEN-1:0] rdData,
    output logic                    fault
);

    memReqIf #(.DEPTH_WORDS(DEPTH_WORDS)) reqLink ();
    memRspIf                              rspLink ();

    lsuAddrGen #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) uAddrGen (
        .clk      (clk),
        .rstN     (rstN),
        .reqValid (reqValid),
        .wrEn     (wrEn),
        .memOp    (memOp),
        .base     (base),
        .offset   (offset),
        .wrData   (wrData),
        .req      (reqLink.src)
    );

    lsuDataMem #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) uDataMem (
        .clk  (clk),
        .rstN (rstN),
        .req  (reqLink.dst),
        .rsp  (rspLink.src)
    );

    lsuLoadAlign uLoadAlign (
        .clk     (clk),
        .rstN    (rstN),
        .rsp     (rspLink.dst),
        .rdValid (rdValid),
        .rdData  (rdData),
        .fault   (fault)
    );

endmodule

/* testbench/lsu_asserts.sv */
// ------------------------------
// Latency and data checks on the load/store top-level ports.
// ------------------------------
`timescale 1ns/1ps

module lsu_asserts (
    input logic                    clk,
    input logic                    rstN,
    input logic                    reqValid,
    input logic                    wrEn,
    input logic                    rdValid,
    input logic [lsuPkg::XLEN-1:0] rdData,
    input logic                    fault
);

    // A request sampled at edge N is seen on the outputs at the sample of edge N+4.
    loadHasResult: assert property (@(posedge clk) disable iff (!rstN)
        $past(reqValid & ~wrEn, 4) |-> rdValid)
        else $error("load result did not arrive at the fixed latency");

    resultHasLoad: assert property (@(posedge clk) disable iff (!rstN)
        rdValid |-> $past(reqValid & ~wrEn, 4))
        else $error("rdValid pulse without a load four cycles earlier");

    faultHasRequest: assert property (@(posedge clk) disable iff (!rstN)
        fault |-> $past(reqValid, 4))
        else $error("fault pulse without a request four cycles earlier");

    dataKnown: assert property (@(posedge clk) disable iff (!rstN)
        rdValid |-> !$isunknown(rdData))
        else $error("rdData holds unknown bits while rdValid is high");

endmodule

/* testbench/lsuTb.sv */
// ------------------------------
// Load/store data path testbench: request table, byte model of memory, checks.
// ------------------------------
`timescale 1ns/1ps

module lsuTb;

    localparam int DEPTH_WORDS = 256;
    localparam int MEM_BYTES   = DEPTH_WORDS * 4;
    localparam int BA          = $clog2(MEM_BYTES);
    localparam int MAX_REQ     = 128;

    typedef struct packed {
        int          cycle;    // cycle count at which the result is sampled.
        int          idx;
        logic        rdValid;
        logic        fault;
        logic [31:0] data;
    } expT;

    logic          clk;
    logic          rstN;
    logic          reqValid;
    logic          wrEn;
    lsuPkg::memOpE memOp;
    logic [31:0]   base;
    logic [31:0]   offset;
    logic [31:0]   wrData;
    logic          rdValid;
    logic [31:0]   rdData;
    logic          fault;

    // ------------------------------
    // stimulus table and model
    // ------------------------------
    logic        tWr    [MAX_REQ];
    logic [2:0]  tOp    [MAX_REQ];
    logic [31:0] tBase  [MAX_REQ];
    logic [31:0] tOff   [MAX_REQ];
    logic [31:0] tData  [MAX_REQ];
    logic [31:0] tExp   [MAX_REQ];
    logic        tFault [MAX_REQ];
    int          nReq;
    logic        tableReady;

    logic [7:0]  memBytes [MEM_BYTES];  // byte image of the data memory.
    expT         expQ [$];
    expT         got;
    expT         entry;
    int          cycleCnt = 0;
    int          checkErrs;
    int          pulseErrs;
    int          seed;

    lsuTop #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .reqValid (reqValid),
        .wrEn     (wrEn),
        .memOp    (memOp),
        .base     (base),
        .offset   (offset),
        .wrData   (wrData),
        .rdValid  (rdValid),
        .rdData   (rdData),
        .fault    (fault)
    );

    bind lsuTop lsu_asserts uAsserts (
        .clk      (clk),
        .rstN     (rstN),
        .reqValid (reqValid),
        .wrEn     (wrEn),
        .rdValid  (rdValid),
        .rdData   (rdData),
        .fault    (fault)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // Applies the access rules to the byte image and appends one table entry.
    task automatic addReq(input logic w, input logic [2:0] op, input logic [31:0] b,
                          input logic [31:0] o, input logic [31:0] d);
        logic [31:0]   addr;
        logic [31:0]   word;
        logic [BA-1:0] bIdx;
        int            size;
        logic          legal;
        logic          bad;
        addr  = b + o;
        size  = (op[1:0] == 2'd0) ? 1 : ((op[1:0] == 2'd1) ? 2 : 4);
        legal = (op == 3'b000) || (op == 3'b001) || (op == 3'b010) ||
                (!w && ((op == 3'b100) || (op == 3'b101)));  // unsigned forms load only.
        bad   = !legal || (addr % size != 0) || (addr >= MEM_BYTES);
        word  = '0;
        for (int i = 0; i < size; i++) begin
            bIdx = addr[BA-1:0] + BA'(i);  // little endian, lowest byte first.
            if (!bad && w) begin
                memBytes[bIdx] = d[8*i +: 8];
            end
            word[8*i +: 8] = memBytes[bIdx];
        end
        if (bad || w) begin
            tExp[nReq] = '0;
        end else if (size == 1) begin
            tExp[nReq] = {{24{word[7] & ~op[2]}}, word[7:0]};  // op bit 2 means zero fill.
        end else if (size == 2) begin
            tExp[nReq] = {{16{word[15] & ~op[2]}}, word[15:0]};
        end else begin
            tExp[nReq] = word;
        end
        tWr[nReq]    = w;
        tOp[nReq]    = op;
        tBase[nReq]  = b;
        tOff[nReq]   = o;
        tData[nReq]  = d;
        tFault[nReq] = bad;
        nReq++;
    endtask

    task automatic buildTable();
        logic [31:0] r;
        for (int w = 0; w < 8; w++) begin
            addReq(1'b1, lsuPkg::memWord, 32'h10, 32'(w * 4 - 16), $random(seed));
        end
        addReq(1'b1, lsuPkg::memWord, 32'h3F0, 32'hC, $random(seed));  // last word.
        for (int w = 0; w < 8; w++) begin
            addReq(1'b0, lsuPkg::memWord, 32'h0, 32'(w * 4), 32'h0);
        end
        addReq(1'b0, lsuPkg::memWord, 32'h400, 32'hFFFF_FFFC, 32'h0);
        for (int k = 0; k < 4; k++) begin
            addReq(1'b1, lsuPkg::memByte, 32'h4, 32'(k), $random(seed));
            addReq(1'b0, lsuPkg::memWord, 32'h4, 32'h0, 32'h0);
        end
        for (int k = 0; k < 2; k++) begin
            addReq(1'b1, lsuPkg::memHalf, 32'h8, 32'(2 - 2 * k), $random(seed));
            addReq(1'b0, lsuPkg::memWord, 32'h8, 32'h0, 32'h0);
        end
        addReq(1'b1, lsuPkg::memWord, 32'h10, 32'h0, 32'h7FFF_8001);
        addReq(1'b1, lsuPkg::memWord, 32'h14, 32'h0, 32'h7F80_0000);
        for (int k = 0; k < 2; k++) begin
            addReq(1'b0, lsuPkg::memByte,  32'h16, 32'(k), 32'h0);
            addReq(1'b0, lsuPkg::memByteU, 32'h16, 32'(k), 32'h0);
            addReq(1'b0, lsuPkg::memHalf,  32'h10, 32'(2 * k), 32'h0);
            addReq(1'b0, lsuPkg::memHalfU, 32'h10, 32'(2 * k), 32'h0);
        end
        // ------------------------------
        // faults, then loads that show memory kept its data
        // ------------------------------
        addReq(1'b0, lsuPkg::memHalf,  32'h18, 32'h1, 32'h0);
        addReq(1'b0, lsuPkg::memHalfU, 32'h18, 32'h3, 32'h0);
        addReq(1'b1, lsuPkg::memHalf,  32'h18, 32'h1, $random(seed));
        addReq(1'b0, lsuPkg::memWord,  32'h18, 32'h2, 32'h0);
        addReq(1'b1, lsuPkg::memWord,  32'h1C, 32'h1, $random(seed));
        addReq(1'b1, lsuPkg::memByteU, 32'h18, 32'h0, $random(seed));
        addReq(1'b1, lsuPkg::memHalfU, 32'h1C, 32'h0, $random(seed));
        addReq(1'b0, 3'b011, 32'h18, 32'h0, 32'h0);
        addReq(1'b1, 3'b110, 32'h18, 32'h0, $random(seed));
        addReq(1'b0, 3'b111, 32'h1C, 32'h0, 32'h0);
        addReq(1'b0, lsuPkg::memWord, 32'h400, 32'h0, 32'h0);
        addReq(1'b1, lsuPkg::memByte, 32'hFFF0, 32'h2B, $random(seed));  // wraps onto 0x1B.
        addReq(1'b0, lsuPkg::memWord, 32'h18, 32'h0, 32'h0);
        addReq(1'b0, lsuPkg::memWord, 32'h1C, 32'h0, 32'h0);
        // store directly followed by a load of the same location.
        addReq(1'b1, lsuPkg::memWord,  32'h18, 32'h0, $random(seed));
        addReq(1'b0, lsuPkg::memWord,  32'h18, 32'h0, 32'h0);
        addReq(1'b1, lsuPkg::memByte,  32'h1C, 32'h1, $random(seed));
        addReq(1'b0, lsuPkg::memByteU, 32'h1C, 32'h1, 32'h0);
        addReq(1'b1, lsuPkg::memHalf,  32'h1C, 32'h2, $random(seed));
        addReq(1'b0, lsuPkg::memHalf,  32'h1C, 32'h2, 32'h0);
        for (int k = 0; k < 16; k++) begin
            r = $random(seed);
            addReq(r[3], r[2:0], 32'h0, {27'd0, r[12:8]}, $random(seed));
        end
    endtask

    // ------------------------------
    // result monitor
    // ------------------------------
    always @(negedge clk) begin
        if (rdValid || fault) begin
            if (expQ.size() == 0) begin
                $display("ERROR: unexpected rdValid or fault pulse at cycle %0d", cycleCnt);
                pulseErrs++;
            end else begin
                got = expQ.pop_front();
                if (got.cycle != cycleCnt) begin
                    $display("ERROR: result of request %0d came at cycle %0d, not at cycle %0d",
                             got.idx, cycleCnt, got.cycle);
                    pulseErrs++;
                end
                if (rdValid !== got.rdValid) begin
                    $display("CHECK FAILED rdValid: expected 0x%0h, got 0x%0h (request %0d)",
                             got.rdValid, rdValid, got.idx);
                    checkErrs++;
                end
                if (fault !== got.fault) begin
                    $display("CHECK FAILED fault: expected 0x%0h, got 0x%0h (request %0d)",
                             got.fault, fault, got.idx);
                    checkErrs++;
                end
                if (got.rdValid && (rdData !== got.data)) begin
                    $display("CHECK FAILED rdData: expected 0x%08h, got 0x%08h (request %0d)",
                             got.data, rdData, got.idx);
                    checkErrs++;
                end
            end
        end else if ((expQ.size() != 0) && (expQ[0].cycle <= cycleCnt)) begin
            got = expQ.pop_front();
            $display("ERROR: no result pulse for request %0d at cycle %0d", got.idx, got.cycle);
            pulseErrs++;
        end
    end

    initial begin
        wait (tableReady);
        #((nReq + 20) * 10);
        $display("ERROR: watchdog expired after %0d ns with the run unfinished",
                 (nReq + 20) * 10);
        $display("errors: %0d value, %0d pulse", checkErrs, pulseErrs);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        seed       = 65;
        nReq       = 0;
        tableReady = 1'b0;
        checkErrs  = 0;
        pulseErrs  = 0;
        clk        = 1'b0;
        rstN       = 1'b0;
        reqValid   = 1'b0;
        wrEn       = 1'b0;
        memOp      = lsuPkg::memByte;
        base       = '0;
        offset     = '0;
        wrData     = '0;
        buildTable();
        tableReady = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        if (rdData !== '0) begin
            $display("CHECK FAILED rdData: expected 0x%08h, got 0x%08h after reset", 0, rdData);
            checkErrs++;
        end
        for (int i = 0; i < nReq; i++) begin
            @(negedge clk);
            reqValid = 1'b1;
            wrEn     = tWr[i];
            memOp    = lsuPkg::memOpE'(tOp[i]);
            base     = tBase[i];
            offset   = tOff[i];
            wrData   = tData[i];
            if (!tWr[i] || tFault[i]) begin  // stores report only when they fault.
                entry.cycle   = cycleCnt + 4;
                entry.idx     = i;
                entry.rdValid = ~tWr[i];
                entry.fault   = tFault[i];
                entry.data    = tExp[i];
                expQ.push_back(entry);
            end
        end
        @(negedge clk);
        reqValid = 1'b0;
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        $display("errors: %0d value, %0d pulse", checkErrs, pulseErrs);
        if ((checkErrs == 0) && (pulseErrs == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
design/lsuPkg.sv
design/lsuStageIf.sv
design/lsuAddrGen.sv
design/lsuDataMem.sv
design/lsuLoadAlign.sv
design/lsuTop.sv
testbench/lsu_asserts.sv
testbench/lsuTb.sv

/* runSim.sh */
#!/bin/sh
# Builds the load/store testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/lsuSim

verilator --binary --timing --assert --top-module lsuTb -Mdir obj_dir -o lsuSim -f tb.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
